// ==== common/aes_pkg.sv ====
package aes_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;

    // First byte in the top bits, column-major, four bytes per column
    typedef logic [127:0] block_t;

    typedef logic [3:0]   round_cnt_t;

    typedef enum logic {
        S_IDLE,
        S_ROUND
    } ctrl_state_e;

    // AES-128 always runs ten rounds
    localparam round_cnt_t NUM_ROUNDS = 4'd10;

    localparam byte_t RCON_FIRST = 8'h01;

    // Forward S-box
    localparam byte_t SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic byte_t sub_byte(input byte_t b);
        return SBOX[b];
    endfunction

    // Multiply by x in GF(2^8), polynomial 0x11b
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

// ==== round/aes_key_step.sv ====
`timescale 1ns/1ps

module aes_key_step
    import aes_pkg::*;
(
    input  block_t key_in,
    input  byte_t  rcon,
    output block_t key_out
);

    word_t w0;
    word_t w1;
    word_t w2;
    word_t w3;
    word_t rot_word;
    word_t sub_word;
    word_t n0;
    word_t n1;
    word_t n2;
    word_t n3;

    assign w0 = key_in[127:96];
    assign w1 = key_in[95:64];
    assign w2 = key_in[63:32];
    assign w3 = key_in[31:0];

    // RotWord then SubWord on the last word
    assign rot_word = {w3[23:0], w3[31:24]};

    // Round constant only touches the top byte
    assign sub_word = {sub_byte(rot_word[31:24]) ^ rcon,
                       sub_byte(rot_word[23:16]),
                       sub_byte(rot_word[15:8]),
                       sub_byte(rot_word[7:0])};

    // Each new word chains off the one before it
    assign n0 = w0 ^ sub_word;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign key_out = {n0, n1, n2, n3};

endmodule

// ==== round/aes_round.sv ====
`timescale 1ns/1ps

module aes_round
    import aes_pkg::*;
(
    input  block_t state_in,
    input  block_t round_key,
    input  logic   final_round,
    output block_t state_out
);

    // Columns after SubBytes and ShiftRows, row 0 in the top byte
    word_t shifted [4];

    function automatic word_t mix_column(input word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // Rows of the circulant matrix 2 3 1 1
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // Row r of output column c comes from input column c + r
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[c][31 - 8 * r -: 8] =
                    sub_byte(state_in[127 - 32 * ((c + r) % 4) - 8 * r -: 8]);
            end
        end
    end

    // MixColumns is skipped in the last round
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            state_out[127 - 32 * c -: 32] =
                (final_round ? shifted[c] : mix_column(shifted[c]))
                ^ round_key[127 - 32 * c -: 32];
        end
    end

endmodule

// ==== round/aes_datapath.sv ====
`timescale 1ns/1ps

module aes_datapath
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   load,
    input  logic   advance,
    input  logic   final_round,
    input  byte_t  rcon,
    input  block_t data_in,
    input  block_t key,
    output block_t data_out
);

    block_t state_q;
    block_t key_q;
    block_t key_next;
    block_t round_out;

    // Next round key is ready in the same cycle it is used
    aes_key_step u_key_step (
        .key_in  (key_q),
        .rcon    (rcon),
        .key_out (key_next)
    );

    aes_round u_round (
        .state_in    (state_q),
        .round_key   (key_next),
        .final_round (final_round),
        .state_out   (round_out)
    );

    // Initial AddRoundKey happens on load
    always_ff @(posedge clk) begin
        if (load) begin
            state_q <= data_in ^ key;
            key_q   <= key;
        end else if (advance) begin
            state_q <= round_out;
            key_q   <= key_next;
        end
    end

    // Result holds until the next block finishes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (final_round) begin
            data_out <= round_out;
        end
    end

    // Controller must never start a block while rounds are running
    a_no_load_in_round : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && advance)
    );

endmodule

// ==== source/aes_ctrl.sv ====
`timescale 1ns/1ps

module aes_ctrl
    import aes_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    output logic  load,
    output logic  advance,
    output logic  final_round,
    output byte_t rcon,
    output logic  busy,
    output logic  done
);

    ctrl_state_e state;
    round_cnt_t  round_cnt;
    logic        last_round;

    assign busy        = (state == S_ROUND);
    assign load        = start && !busy;
    assign advance     = busy;
    assign last_round  = (round_cnt == NUM_ROUNDS);
    assign final_round = advance && last_round;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            round_cnt <= '0;
            rcon      <= RCON_FIRST;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load) begin
                        state     <= S_ROUND;
                        round_cnt <= round_cnt_t'(1);
                        rcon      <= RCON_FIRST;
                    end
                end
                S_ROUND: begin
                    if (last_round) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end else begin
                        round_cnt <= round_cnt + round_cnt_t'(1);
                        // Round constants are successive powers of x
                        rcon      <= xtime(rcon);
                    end
                end
            endcase
        end
    end

    a_done_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

    a_round_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        round_cnt <= NUM_ROUNDS
    );

    // A load is accepted while idle and the core is busy on the next cycle
    a_load_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !busy ##1 busy
    );

endmodule

// ==== source/aes_core.sv ====
`timescale 1ns/1ps

module aes_core
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  block_t data_in,
    input  block_t key,
    output logic   busy,
    output logic   done,
    output block_t data_out
);

    logic  load;
    logic  advance;
    logic  final_round;
    byte_t rcon;

    // All sequencing lives in the controller
    aes_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .load        (load),
        .advance     (advance),
        .final_round (final_round),
        .rcon        (rcon),
        .busy        (busy),
        .done        (done)
    );

    aes_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .advance     (advance),
        .final_round (final_round),
        .rcon        (rcon),
        .data_in     (data_in),
        .key         (key),
        .data_out    (data_out)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);

    logic por_n;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Power-on reset held for four cycles and released away from the rising edge
    initial begin
        por_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        por_n = 1'b1;
    end

    // Testbench may also pull reset low during a run
    assign rst_n = por_n && !rst_req;

endmodule

// ==== verif/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb
    import aes_pkg::*;
();

    localparam int DONE_TIMEOUT = 20;

    // Known-answer vectors for AES-128
    localparam block_t KEY_SAMPLE = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t PT_SAMPLE  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam block_t CT_SAMPLE  = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam block_t KEY_SEQ    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t PT_SEQ     = 128'h00112233445566778899aabbccddeeff;
    localparam block_t CT_SEQ     = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam block_t CT_ZERO    = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic   clk;
    logic   rst_n;
    logic   rst_req;
    logic   start;
    block_t data_in;
    block_t key;
    logic   busy;
    logic   done;
    block_t data_out;

    int errors;
    int checks;
    int timeouts;

    tb_clock u_clock (
        .rst_req (rst_req),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    aes_core dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .data_in  (data_in),
        .key      (key),
        .busy     (busy),
        .done     (done),
        .data_out (data_out)
    );

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Inputs change 1 ns after the rising edge so outputs are settled by then
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_start(input block_t pt, input block_t k);
        start   = 1'b1;
        data_in = pt;
        key     = k;
        next_cycle();
        start   = 1'b0;
    endtask

    // Counts rising edges from just after the accepting edge until done
    task automatic wait_done(output int edges);
        edges = 0;
        while (!done && edges < DONE_TIMEOUT) begin
            next_cycle();
            edges++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < DONE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic encrypt_sample_cipher();
        int edges;
        drive_start(PT_SAMPLE, KEY_SAMPLE);
        wait_done(edges);
        check_block("data_out", data_out, CT_SAMPLE);
        next_cycle();
    endtask

    task automatic encrypt_example_keys();
        int edges;
        drive_start(PT_SEQ, KEY_SEQ);
        wait_done(edges);
        check_block("data_out", data_out, CT_SEQ);
        next_cycle();
        drive_start('0, '0);
        wait_done(edges);
        check_block("data_out", data_out, CT_ZERO);
        next_cycle();
    endtask

    task automatic measure_done_timing();
        int edges;
        drive_start(PT_SEQ, KEY_SEQ);
        check_bit("busy", busy, 1'b1);
        check_bit("done", done, 1'b0);
        edges = 0;
        while (!done && edges < DONE_TIMEOUT) begin
            check_bit("busy", busy, 1'b1);
            next_cycle();
            edges++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
        end
        check_count("done latency", edges, int'(NUM_ROUNDS));
        check_bit("busy", busy, 1'b0);
        check_block("data_out", data_out, CT_SEQ);
        // One-cycle done and the result held afterward
        repeat (5) begin
            next_cycle();
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
            check_block("data_out", data_out, CT_SEQ);
        end
    endtask

    task automatic ignore_start_while_busy();
        int edges;
        int pulses;
        drive_start(PT_SAMPLE, KEY_SAMPLE);
        repeat (3) next_cycle();
        // Second block mid-run with different data
        start   = 1'b1;
        data_in = PT_SEQ;
        key     = KEY_SEQ;
        next_cycle();
        start   = 1'b0;
        wait_done(edges);
        check_block("data_out", data_out, CT_SAMPLE);
        pulses = 0;
        repeat (15) begin
            next_cycle();
            if (done) begin
                pulses++;
            end
        end
        check_count("extra done pulses", pulses, 0);
        check_bit("busy", busy, 1'b0);
        check_block("data_out", data_out, CT_SAMPLE);
    endtask

    task automatic chain_back_to_back();
        int edges;
        drive_start(PT_SEQ, KEY_SEQ);
        wait_done(edges);
        check_block("data_out", data_out, CT_SEQ);
        // Next block starts in the done cycle
        drive_start(PT_SAMPLE, KEY_SAMPLE);
        check_bit("busy", busy, 1'b1);
        wait_done(edges);
        check_count("done latency", edges, int'(NUM_ROUNDS));
        check_block("data_out", data_out, CT_SAMPLE);
        next_cycle();
    endtask

    task automatic reset_during_run();
        int edges;
        drive_start(PT_SEQ, KEY_SEQ);
        repeat (4) next_cycle();
        check_bit("busy", busy, 1'b1);
        rst_req = 1'b1;
        repeat (2) next_cycle();
        rst_req = 1'b0;
        next_cycle();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_block("data_out", data_out, '0);
        drive_start(PT_SAMPLE, KEY_SAMPLE);
        wait_done(edges);
        check_count("done latency", edges, int'(NUM_ROUNDS));
        check_block("data_out", data_out, CT_SAMPLE);
        next_cycle();
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        rst_req  = 1'b0;
        start    = 1'b0;
        data_in  = '0;
        key      = '0;

        wait_reset_release();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_block("data_out", data_out, '0);
        next_cycle();

        encrypt_sample_cipher();
        encrypt_example_keys();
        measure_done_timing();
        ignore_start_while_busy();
        chain_back_to_back();
        reset_during_run();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== aes_core.f ====
common/aes_pkg.sv
round/aes_key_step.sv
round/aes_round.sv
round/aes_datapath.sv
source/aes_ctrl.sv
source/aes_core.sv
verif/tb_clock.sv
verif/aes_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=aes_core_sim

verilator --binary --timing --assert -f aes_core.f \
    --top-module aes_core_tb --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
